// ==== Bender.yml ====
package:
  name: tap_rtdr

sources:
  - tap_rtdr_pkg.sv
  - tap_fsm.sv
  - tap_instr_path.sv
  - tap_remote_dr_ctl.sv
  - rtdr_ip_reg.sv
  - tap_rtdr_top.sv
  - target: test
    files:
      - tb_tap_rtdr.sv

// ==== rtdr_ip_reg.sv ====
// remote test data register, tck shift chain with ip-side status snapshot and control register
`timescale 1ns/1ps

module rtdr_ip_reg
   (
   input  logic                                  atappris_tck,
   input  logic                                  powergoodrst_b,
   input  logic                                  rtdr_tap_ip_clk_i,
   input  tap_rtdr_pkg::rtdr_if_s                rtdr,
   input  logic [tap_rtdr_pkg::RTDR_WIDTH-1:0]   ip_status,
   output logic                                  rtdr_tdo,
   output logic [tap_rtdr_pkg::RTDR_WIDTH-1:0]   ip_ctrl
   );

   // *******************************************************************
   // internal signals
   // *******************************************************************
   logic [tap_rtdr_pkg::RTDR_WIDTH-1:0] status_hold;
   logic [tap_rtdr_pkg::RTDR_WIDTH-1:0] chain;
   logic                                shift_q;
   logic                                first_shift;

   // *******************************************************************
   // ip side status snapshot
   // *******************************************************************
   // held stable from capture-dr until the scan reads it
   always_ff @(posedge rtdr_tap_ip_clk_i)
   begin
      if (rtdr.capture && rtdr.irdec)
      begin
         status_hold <= ip_status;
      end
   end

   // *******************************************************************
   // tck shift chain
   // *******************************************************************
   // first shift cycle found locally from the shift level
   always_ff @(posedge atappris_tck or negedge powergoodrst_b)
   begin
      if (!powergoodrst_b)
      begin
         shift_q <= 1'b0;
      end
      else
      begin
         shift_q <= rtdr.shift;
      end
   end

   assign first_shift = rtdr.shift & ~shift_q;

   always_ff @(posedge atappris_tck or negedge powergoodrst_b)
   begin
      if (!powergoodrst_b)
      begin
         chain <= '0;
      end
      else if (first_shift)
      begin
         // parallel load and first shift in one step
         chain <= {rtdr.tdi, status_hold[tap_rtdr_pkg::RTDR_WIDTH-1:1]};
      end
      else if (rtdr.shift)
      begin
         chain <= {rtdr.tdi, chain[tap_rtdr_pkg::RTDR_WIDTH-1:1]};
      end
   end

   assign rtdr_tdo = first_shift ? status_hold[0] : chain[0];

   // *******************************************************************
   // ip side control register
   // *******************************************************************
   always_ff @(posedge rtdr_tap_ip_clk_i or negedge powergoodrst_b)
   begin
      if (!powergoodrst_b)
      begin
         ip_ctrl <= '0;
      end
      else if (rtdr.update)
      begin
         ip_ctrl <= chain;
      end
   end

   // synchronized update must still see the synchronized select
   a_upd_irdec: assert property (
      @(posedge rtdr_tap_ip_clk_i) disable iff (!powergoodrst_b)
      rtdr.update |-> rtdr.irdec
   );

endmodule

// ==== tap_fsm.sv ====
// tap controller fsm, steps the sixteen 1149.1 states and decodes the dr/ir controls
`timescale 1ns/1ps

module tap_fsm
   (
   input  logic                  atappris_tck,
   input  logic                  powergoodrst_b,
   input  logic                  atappris_tms,
   output tap_rtdr_pkg::tap_ctl_s tap_ctl
   );

   // *******************************************************************
   // state register
   // *******************************************************************
   tap_rtdr_pkg::tap_state_t state;
   tap_rtdr_pkg::tap_state_t state_nxt;

   // powergood reset parks the tap in test-logic-reset
   always_ff @(posedge atappris_tck or negedge powergoodrst_b)
   begin
      if (!powergoodrst_b)
      begin
         state <= tap_rtdr_pkg::TAP_TLR;
      end
      else
      begin
         state <= state_nxt;
      end
   end

   // *******************************************************************
   // next state from tms
   // *******************************************************************
   always_comb
   begin
      unique case (state)
         tap_rtdr_pkg::TAP_TLR:
            state_nxt = atappris_tms ? tap_rtdr_pkg::TAP_TLR : tap_rtdr_pkg::TAP_RTI;
         tap_rtdr_pkg::TAP_RTI:
            state_nxt = atappris_tms ? tap_rtdr_pkg::TAP_SEL_DR : tap_rtdr_pkg::TAP_RTI;
         // dr column
         tap_rtdr_pkg::TAP_SEL_DR:
            state_nxt = atappris_tms ? tap_rtdr_pkg::TAP_SEL_IR : tap_rtdr_pkg::TAP_CAPTURE_DR;
         tap_rtdr_pkg::TAP_CAPTURE_DR:
            state_nxt = atappris_tms ? tap_rtdr_pkg::TAP_EXIT1_DR : tap_rtdr_pkg::TAP_SHIFT_DR;
         tap_rtdr_pkg::TAP_SHIFT_DR:
            state_nxt = atappris_tms ? tap_rtdr_pkg::TAP_EXIT1_DR : tap_rtdr_pkg::TAP_SHIFT_DR;
         tap_rtdr_pkg::TAP_EXIT1_DR:
            state_nxt = atappris_tms ? tap_rtdr_pkg::TAP_UPDATE_DR : tap_rtdr_pkg::TAP_PAUSE_DR;
         tap_rtdr_pkg::TAP_PAUSE_DR:
            state_nxt = atappris_tms ? tap_rtdr_pkg::TAP_EXIT2_DR : tap_rtdr_pkg::TAP_PAUSE_DR;
         tap_rtdr_pkg::TAP_EXIT2_DR:
            state_nxt = atappris_tms ? tap_rtdr_pkg::TAP_UPDATE_DR : tap_rtdr_pkg::TAP_SHIFT_DR;
         tap_rtdr_pkg::TAP_UPDATE_DR:
            state_nxt = atappris_tms ? tap_rtdr_pkg::TAP_SEL_DR : tap_rtdr_pkg::TAP_RTI;
         // ir column
         tap_rtdr_pkg::TAP_SEL_IR:
            state_nxt = atappris_tms ? tap_rtdr_pkg::TAP_TLR : tap_rtdr_pkg::TAP_CAPTURE_IR;
         tap_rtdr_pkg::TAP_CAPTURE_IR:
            state_nxt = atappris_tms ? tap_rtdr_pkg::TAP_EXIT1_IR : tap_rtdr_pkg::TAP_SHIFT_IR;
         tap_rtdr_pkg::TAP_SHIFT_IR:
            state_nxt = atappris_tms ? tap_rtdr_pkg::TAP_EXIT1_IR : tap_rtdr_pkg::TAP_SHIFT_IR;
         tap_rtdr_pkg::TAP_EXIT1_IR:
            state_nxt = atappris_tms ? tap_rtdr_pkg::TAP_UPDATE_IR : tap_rtdr_pkg::TAP_PAUSE_IR;
         tap_rtdr_pkg::TAP_PAUSE_IR:
            state_nxt = atappris_tms ? tap_rtdr_pkg::TAP_EXIT2_IR : tap_rtdr_pkg::TAP_PAUSE_IR;
         tap_rtdr_pkg::TAP_EXIT2_IR:
            state_nxt = atappris_tms ? tap_rtdr_pkg::TAP_UPDATE_IR : tap_rtdr_pkg::TAP_SHIFT_IR;
         tap_rtdr_pkg::TAP_UPDATE_IR:
            state_nxt = atappris_tms ? tap_rtdr_pkg::TAP_SEL_DR : tap_rtdr_pkg::TAP_RTI;
         default:
            state_nxt = tap_rtdr_pkg::TAP_TLR;
      endcase
   end

   // *******************************************************************
   // control decode
   // *******************************************************************
   // current state controls
   assign tap_ctl.capture_dr  = (state == tap_rtdr_pkg::TAP_CAPTURE_DR);
   assign tap_ctl.shift_dr    = (state == tap_rtdr_pkg::TAP_SHIFT_DR);
   assign tap_ctl.update_dr   = (state == tap_rtdr_pkg::TAP_UPDATE_DR);
   assign tap_ctl.capture_ir  = (state == tap_rtdr_pkg::TAP_CAPTURE_IR);
   assign tap_ctl.shift_ir    = (state == tap_rtdr_pkg::TAP_SHIFT_IR);
   assign tap_ctl.update_ir   = (state == tap_rtdr_pkg::TAP_UPDATE_IR);
   assign tap_ctl.reset_state = (state == tap_rtdr_pkg::TAP_TLR);

   // look-ahead controls, a flop on these lines up with the state
   assign tap_ctl.capture_dr_nxt = (state_nxt == tap_rtdr_pkg::TAP_CAPTURE_DR);
   assign tap_ctl.update_dr_nxt  = (state_nxt == tap_rtdr_pkg::TAP_UPDATE_DR);

   // five tms highs from anywhere must land in test-logic-reset
   a_tms_reset: assert property (
      @(posedge atappris_tck) disable iff (!powergoodrst_b)
      atappris_tms [*5] |=> (state == tap_rtdr_pkg::TAP_TLR)
   );

endmodule

// ==== tap_instr_path.sv ====
// tap instruction path with ir shift and update stages, opcode decode, bypass bit and tdo mux
`timescale 1ns/1ps

module tap_instr_path
   (
   input  logic                   atappris_tck,
   input  logic                   powergoodrst_b,
   input  logic                   atappris_tdi,
   input  tap_rtdr_pkg::tap_ctl_s tap_ctl,
   input  logic                   rtdr_drout,
   output logic                   rtdr_drselect,
   output logic                   atappris_tdo
   );

   // *******************************************************************
   // internal signals
   // *******************************************************************
   logic [tap_rtdr_pkg::IR_WIDTH-1:0] ir_shift;
   logic [tap_rtdr_pkg::IR_WIDTH-1:0] ir_reg;
   logic                              bypass_bit;

   // *******************************************************************
   // instruction register
   // *******************************************************************
   // shift stage, loads the capture pattern then shifts lsb first
   always_ff @(posedge atappris_tck or negedge powergoodrst_b)
   begin
      if (!powergoodrst_b)
      begin
         ir_shift <= tap_rtdr_pkg::IR_RESET;
      end
      else if (tap_ctl.capture_ir)
      begin
         ir_shift <= tap_rtdr_pkg::IR_CAPTURE;
      end
      else if (tap_ctl.shift_ir)
      begin
         ir_shift <= {atappris_tdi, ir_shift[tap_rtdr_pkg::IR_WIDTH-1:1]};
      end
   end

   // update stage, changes on the edge that leaves update-ir
   always_ff @(posedge atappris_tck or negedge powergoodrst_b)
   begin
      if (!powergoodrst_b)
      begin
         ir_reg <= tap_rtdr_pkg::IR_RESET;
      end
      else if (tap_ctl.reset_state)
      begin
         ir_reg <= tap_rtdr_pkg::IR_RESET;
      end
      else if (tap_ctl.update_ir)
      begin
         ir_reg <= ir_shift;
      end
   end

   // only the remote register opcode is decoded, all else is bypass
   assign rtdr_drselect = (ir_reg == tap_rtdr_pkg::OPC_RTDR);

   // *******************************************************************
   // bypass register
   // *******************************************************************
   always_ff @(posedge atappris_tck or negedge powergoodrst_b)
   begin
      if (!powergoodrst_b)
      begin
         bypass_bit <= 1'b0;
      end
      else if (tap_ctl.capture_dr)
      begin
         bypass_bit <= 1'b0;
      end
      else if (tap_ctl.shift_dr)
      begin
         bypass_bit <= atappris_tdi;
      end
   end

   // *******************************************************************
   // tdo select
   // *******************************************************************
   // shows the bit that leaves on the next rising edge
   always_comb
   begin
      if (tap_ctl.shift_dr)
      begin
         atappris_tdo = rtdr_drselect ? rtdr_drout : bypass_bit;
      end
      else if (tap_ctl.shift_ir)
      begin
         atappris_tdo = ir_shift[0];
      end
      else
      begin
         atappris_tdo = 1'b0;
      end
   end

   // dr and ir shift states are exclusive
   a_shift_excl: assert property (
      @(posedge atappris_tck) disable iff (!powergoodrst_b)
      !(tap_ctl.shift_dr && tap_ctl.shift_ir)
   );

endmodule

// ==== tap_remote_dr_ctl.sv ====
// remote dr control, qualifies dr controls by selection and carries capture/update into the ip clock
`timescale 1ns/1ps

module tap_remote_dr_ctl
   (
   input  logic                   atappris_tck,
   input  logic                   powergoodrst_b,
   input  logic                   rtdr_tap_ip_clk_i,
   input  logic                   atappris_tdi,
   input  tap_rtdr_pkg::tap_ctl_s tap_ctl,
   input  logic                   rtdr_drselect,
   input  logic                   rtdr_tdo,
   output tap_rtdr_pkg::rtdr_if_s rtdr,
   output logic                   rtdr_drout
   );

   // *******************************************************************
   // internal signals
   // *******************************************************************
   // bit 0 capture, bit 1 update
   logic [1:0] pulse_nxt;
   logic [1:0] stretch_ff1;
   logic [1:0] stretch_ff2;

   // bit 2 irdec level, bits 1:0 stretched pulses
   logic [2:0] sync_ff1;
   logic [2:0] sync_ff2;
   logic [1:0] edge_ff;
   logic [1:0] ip_pulse;

   // *******************************************************************
   // tck side, qualify and stretch
   // *******************************************************************
   assign pulse_nxt = {tap_ctl.update_dr_nxt, tap_ctl.capture_dr_nxt} & {2{rtdr_drselect}};

   // ff1 is one tck wide and aligned with the state
   // ff2 holds it for one more tck so a slow ip clock still sees it
   always_ff @(posedge atappris_tck or negedge powergoodrst_b)
   begin
      if (!powergoodrst_b)
      begin
         stretch_ff1 <= 2'b00;
         stretch_ff2 <= 2'b00;
      end
      else
      begin
         stretch_ff1 <= pulse_nxt;
         stretch_ff2 <= stretch_ff1 | pulse_nxt;
      end
   end

   // *******************************************************************
   // ip clock side, two-flop sync plus edge detect
   // *******************************************************************
   always_ff @(posedge rtdr_tap_ip_clk_i or negedge powergoodrst_b)
   begin
      if (!powergoodrst_b)
      begin
         sync_ff1 <= 3'b000;
         sync_ff2 <= 3'b000;
         edge_ff  <= 2'b00;
      end
      else
      begin
         sync_ff1 <= {rtdr_drselect, stretch_ff2};
         sync_ff2 <= sync_ff1;
         edge_ff  <= sync_ff2[1:0];
      end
   end

   // rising edge gives one ip cycle per tck pulse
   assign ip_pulse = sync_ff2[1:0] & ~edge_ff;

   // *******************************************************************
   // remote register interface
   // *******************************************************************
   assign rtdr.capture = ip_pulse[0];
   assign rtdr.update  = ip_pulse[1];
   assign rtdr.irdec   = sync_ff2[2];

   // shift and tdi stay in tck, the chain itself runs on tck
   assign rtdr.shift = tap_ctl.shift_dr & rtdr_drselect;
   assign rtdr.tdi   = atappris_tdi & rtdr_drselect;

   // return path toward the tdo mux
   assign rtdr_drout = rtdr_tdo & rtdr_drselect & tap_ctl.shift_dr;

   // capture and update come from states at least two tck apart
   a_cap_upd_excl: assert property (
      @(posedge rtdr_tap_ip_clk_i) disable iff (!powergoodrst_b)
      !(rtdr.capture && rtdr.update)
   );

endmodule

// ==== tap_rtdr.f ====
tap_rtdr_pkg.sv
tap_fsm.sv
tap_instr_path.sv
tap_remote_dr_ctl.sv
rtdr_ip_reg.sv
tap_rtdr_top.sv
tb_tap_rtdr.sv

// ==== tap_rtdr_pkg.sv ====
// tap remote test data register package with tap states, control bundles, widths and opcodes
package tap_rtdr_pkg;

   // *******************************************************************
   // widths and opcodes
   // *******************************************************************
   localparam int unsigned IR_WIDTH   = 4;
   localparam int unsigned RTDR_WIDTH = 16;

   localparam logic [IR_WIDTH-1:0] OPC_RTDR   = 4'h5;
   localparam logic [IR_WIDTH-1:0] OPC_BYPASS = 4'hF;
   // ir capture pattern, lsb must be 1 per 1149.1
   localparam logic [IR_WIDTH-1:0] IR_CAPTURE = 4'b0001;
   localparam logic [IR_WIDTH-1:0] IR_RESET   = OPC_BYPASS;

   // *******************************************************************
   // tap controller states, 1149.1 style encoding
   // *******************************************************************
   typedef enum logic [3:0] {
      TAP_EXIT2_DR  = 4'h0,
      TAP_EXIT1_DR  = 4'h1,
      TAP_SHIFT_DR  = 4'h2,
      TAP_PAUSE_DR  = 4'h3,
      TAP_SEL_IR    = 4'h4,
      TAP_UPDATE_DR = 4'h5,
      TAP_CAPTURE_DR = 4'h6,
      TAP_SEL_DR    = 4'h7,
      TAP_EXIT2_IR  = 4'h8,
      TAP_EXIT1_IR  = 4'h9,
      TAP_SHIFT_IR  = 4'hA,
      TAP_PAUSE_IR  = 4'hB,
      TAP_RTI       = 4'hC,
      TAP_UPDATE_IR = 4'hD,
      TAP_CAPTURE_IR = 4'hE,
      TAP_TLR       = 4'hF
   } tap_state_t;

   // decoded tap controls, _nxt fields look one state ahead
   typedef struct packed {
      logic capture_dr;
      logic shift_dr;
      logic update_dr;
      logic capture_dr_nxt;
      logic update_dr_nxt;
      logic capture_ir;
      logic shift_ir;
      logic update_ir;
      logic reset_state;
   } tap_ctl_s;

   // interface toward the remote register
   typedef struct packed {
      logic tdi;
      logic capture;
      logic shift;
      logic update;
      logic irdec;
   } rtdr_if_s;

endpackage

// ==== tap_rtdr_testdata.txt ====
// six hex words per record: op (0 reset, 1 ir scan, 2 dr scan, 3 idle), length,
// shift-in, expected shift-out, ip_status (10000 = random), expected ip_ctrl

// tms reset after power-up, then a dr scan in the reset instruction acts as bypass
0 5 0000 0000 0000 0000
2 8 00A5 004A 0000 0000

// load the remote register opcode, ir shifts out the capture pattern
1 4 0005 0001 0000 0000

// remote register scans, fixed status then random status
2 10 3C96 1234 1234 3C96
2 10 A5F0 0000 10000 A5F0
2 10 0F0F 0000 10000 0F0F
2 10 FFFF 0000 10000 FFFF
3 6 0000 0000 0000 FFFF

// bypass opcode, ip_ctrl holds
1 4 000F 0001 0000 FFFF
2 10 1234 2468 0000 FFFF

// back to the remote register
1 4 0005 0001 0000 FFFF
2 10 6A5C 0000 10000 6A5C

// tms reset returns the ir to bypass, ip_ctrl holds
0 5 0000 0000 0000 6A5C
2 10 BEEF 7DDE 0000 6A5C

// an unused opcode also selects bypass
1 4 000A 0001 0000 6A5C
2 10 8001 0002 5555 6A5C

// ==== tap_rtdr_top.sv ====
// tap slice top, tap fsm and instruction path driving one remote test data register
`timescale 1ns/1ps

module tap_rtdr_top
   (
   input  logic                                atappris_tck,
   input  logic                                powergoodrst_b,
   input  logic                                atappris_tms,
   input  logic                                atappris_tdi,
   input  logic                                rtdr_tap_ip_clk_i,
   input  logic [tap_rtdr_pkg::RTDR_WIDTH-1:0] ip_status,
   output logic                                atappris_tdo,
   output logic [tap_rtdr_pkg::RTDR_WIDTH-1:0] ip_ctrl
   );

   // *******************************************************************
   // interconnect
   // *******************************************************************
   tap_rtdr_pkg::tap_ctl_s tap_ctl;
   tap_rtdr_pkg::rtdr_if_s rtdr;
   logic                   rtdr_drselect;
   logic                   rtdr_drout;
   logic                   rtdr_tdo;

   // tap state machine
   tap_fsm tap_fsm_inst (
      .atappris_tck   (atappris_tck),
      .powergoodrst_b (powergoodrst_b),
      .atappris_tms   (atappris_tms),
      .tap_ctl        (tap_ctl)
   );

   // ir, bypass and tdo
   tap_instr_path tap_instr_path_inst (
      .atappris_tck   (atappris_tck),
      .powergoodrst_b (powergoodrst_b),
      .atappris_tdi   (atappris_tdi),
      .tap_ctl        (tap_ctl),
      .rtdr_drout     (rtdr_drout),
      .rtdr_drselect  (rtdr_drselect),
      .atappris_tdo   (atappris_tdo)
   );

   // gating and clock crossing toward the remote register
   tap_remote_dr_ctl tap_remote_dr_ctl_inst (
      .atappris_tck      (atappris_tck),
      .powergoodrst_b    (powergoodrst_b),
      .rtdr_tap_ip_clk_i (rtdr_tap_ip_clk_i),
      .atappris_tdi      (atappris_tdi),
      .tap_ctl           (tap_ctl),
      .rtdr_drselect     (rtdr_drselect),
      .rtdr_tdo          (rtdr_tdo),
      .rtdr              (rtdr),
      .rtdr_drout        (rtdr_drout)
   );

   // remote register in the ip
   rtdr_ip_reg rtdr_ip_reg_inst (
      .atappris_tck      (atappris_tck),
      .powergoodrst_b    (powergoodrst_b),
      .rtdr_tap_ip_clk_i (rtdr_tap_ip_clk_i),
      .rtdr              (rtdr),
      .ip_status         (ip_status),
      .rtdr_tdo          (rtdr_tdo),
      .ip_ctrl           (ip_ctrl)
   );

endmodule

// ==== tb_tap_rtdr.sv ====
// testbench for the tap remote test data register slice, jtag scans replayed from a data file
`timescale 1ns/1ps

module tb_tap_rtdr;

   // *******************************************************************
   // constants
   // *******************************************************************
   localparam int TCK_HALF     = 50;
   localparam int IP_HALF      = 17;
   // tdo sampled this long before the rising edge
   localparam int SAMPLE_LEAD  = 5;
   localparam int RESET_CYCLES = 4;
   localparam int NUM_REC      = 16;
   localparam int REC_WORDS    = 6;
   localparam int PAUSE_CYCLES = 8;
   localparam int IDLE_CYCLES  = 8;

   // record opcodes
   localparam logic [31:0] OP_RESET = 32'd0;
   localparam logic [31:0] OP_IR    = 32'd1;
   localparam logic [31:0] OP_DR    = 32'd2;
   localparam logic [31:0] OP_IDLE  = 32'd3;
   // status word with this bit set asks for a random ip_status
   localparam int RANDOM_BIT = 16;

   // *******************************************************************
   // dut signals and test state
   // *******************************************************************
   logic                                atappris_tck;
   logic                                powergoodrst_b;
   logic                                atappris_tms;
   logic                                atappris_tdi;
   logic                                rtdr_tap_ip_clk_i;
   logic [tap_rtdr_pkg::RTDR_WIDTH-1:0] ip_status;
   logic                                atappris_tdo;
   logic [tap_rtdr_pkg::RTDR_WIDTH-1:0] ip_ctrl;

   logic [31:0] test_mem [0:NUM_REC*REC_WORDS-1];
   integer      seed;
   int          cycle_cnt;
   int          cycle_limit;
   int          total_cycles;

   tap_rtdr_top tap_rtdr_top_inst (
      .atappris_tck      (atappris_tck),
      .powergoodrst_b    (powergoodrst_b),
      .atappris_tms      (atappris_tms),
      .atappris_tdi      (atappris_tdi),
      .rtdr_tap_ip_clk_i (rtdr_tap_ip_clk_i),
      .ip_status         (ip_status),
      .atappris_tdo      (atappris_tdo),
      .ip_ctrl           (ip_ctrl)
   );

   // *******************************************************************
   // clocks and cycle limit
   // *******************************************************************
   always #TCK_HALF atappris_tck = ~atappris_tck;

   // ip clock phase offset keeps its edges off every tck edge
   initial
   begin
      rtdr_tap_ip_clk_i = 1'b0;
      #3.3;
      forever #IP_HALF rtdr_tap_ip_clk_i = ~rtdr_tap_ip_clk_i;
   end

   always @(posedge atappris_tck)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
      begin
         $display("timeout, the run went past its limit of %0d tck cycles", cycle_limit);
         $display("Test failed");
         $fatal(1, "cycle limit reached");
      end
   end

   // *******************************************************************
   // checking
   // *******************************************************************
   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected)
      begin
         $display("[ERROR] time %0t: %s mismatch, got %h expected %h",
                  $time, what, actual, expected);
         $display("Test failed");
         $fatal(1, "value check failed");
      end
   endtask

   // tck cycles one record takes, used for the run limit
   function automatic int record_cycles(input logic [31:0] op, input logic [31:0] len);
      int n;
      n = int'(len);
      case (op)
         OP_RESET: record_cycles = n + 1;
         OP_IR:    record_cycles = n + 6;
         OP_DR:    record_cycles = n + 5 + PAUSE_CYCLES + IDLE_CYCLES + 4;
         default:  record_cycles = n;
      endcase
   endfunction

   // *******************************************************************
   // jtag pin sequences
   // *******************************************************************
   // drive on the falling edge, sample tdo just before the rising edge
   task automatic tck_step(input logic tms_v, input logic tdi_v, output logic tdo_v);
      @(negedge atappris_tck);
      atappris_tms = tms_v;
      atappris_tdi = tdi_v;
      #(TCK_HALF - SAMPLE_LEAD);
      tdo_v = atappris_tdo;
      @(posedge atappris_tck);
   endtask

   // hold tms for a number of cycles, tdi low and tdo ignored
   task automatic move_tms(input logic tms_v, input int count);
      logic unused_tdo;
      repeat (count)
      begin
         tck_step(tms_v, 1'b0, unused_tdo);
      end
   endtask

   // lsb first, tms rises with the last bit to reach exit1
   task automatic shift_bits(input int len, input logic [31:0] data_in,
                             output logic [31:0] data_out);
      logic bit_out;
      data_out = '0;
      for (int i = 0; i < len; i++)
      begin
         tck_step(i == len - 1, data_in[i], bit_out);
         data_out[i] = bit_out;
      end
   endtask

   // tms high walk into test-logic-reset, then park in run-test/idle
   task automatic reset_walk(input int len);
      move_tms(1'b1, len);
      move_tms(1'b0, 1);
   endtask

   // rti -> sel-dr -> sel-ir -> capture-ir -> shift-ir ... update-ir -> rti
   task automatic ir_scan(input int len, input logic [31:0] data_in,
                          output logic [31:0] data_out);
      move_tms(1'b1, 2);
      move_tms(1'b0, 2);
      shift_bits(len, data_in, data_out);
      move_tms(1'b1, 1);
      move_tms(1'b0, 1);
   endtask

   // capture, wait in pause-dr for the ip side, shift, update, wait in rti
   task automatic dr_scan(input int len, input logic [31:0] data_in,
                          input logic [15:0] status_v, output logic [31:0] data_out);
      @(negedge atappris_tck);
      ip_status = status_v;
      move_tms(1'b1, 1);
      move_tms(1'b0, 1);
      move_tms(1'b1, 1);
      move_tms(1'b0, 1 + PAUSE_CYCLES);
      move_tms(1'b1, 1);
      move_tms(1'b0, 1);
      shift_bits(len, data_in, data_out);
      move_tms(1'b1, 1);
      move_tms(1'b0, 1 + IDLE_CYCLES);
   endtask

   // *******************************************************************
   // record player
   // *******************************************************************
   task automatic run_record(input int rec);
      logic [31:0] op;
      logic [31:0] len;
      logic [31:0] sin;
      logic [31:0] sout_exp;
      logic [31:0] status_f;
      logic [31:0] ctrl_exp;
      logic [31:0] sout_act;
      logic [31:0] mask;
      logic [31:0] rnd;
      logic [15:0] status_v;
      op       = test_mem[rec*REC_WORDS];
      len      = test_mem[rec*REC_WORDS+1];
      sin      = test_mem[rec*REC_WORDS+2];
      sout_exp = test_mem[rec*REC_WORDS+3];
      status_f = test_mem[rec*REC_WORDS+4];
      ctrl_exp = test_mem[rec*REC_WORDS+5];
      mask     = (len >= 32) ? 32'hFFFF_FFFF : ((32'h1 << len) - 32'h1);
      case (op)
         OP_RESET:
            reset_walk(len);
         OP_IR:
         begin
            ir_scan(len, sin, sout_act);
            check_value(sout_act, sout_exp & mask, $sformatf("record %0d ir shift-out", rec));
         end
         OP_DR:
         begin
            // random status is also what the scan must read back
            if (status_f[RANDOM_BIT])
            begin
               rnd      = $random(seed);
               status_v = rnd[15:0];
               sout_exp = {16'h0000, status_v};
            end
            else
            begin
               status_v = status_f[15:0];
            end
            dr_scan(len, sin, status_v, sout_act);
            check_value(sout_act, sout_exp & mask, $sformatf("record %0d dr shift-out", rec));
         end
         OP_IDLE:
            move_tms(1'b0, len);
         default:
         begin
            $display("test data record %0d has an unknown opcode %0h", rec, op);
            $display("Test failed");
            $fatal(1, "bad test data");
         end
      endcase
      // ip edges never coincide with tck edges, so ip_ctrl is settled here
      check_value({16'h0000, ip_ctrl}, ctrl_exp, $sformatf("record %0d ip_ctrl", rec));
   endtask

   // *******************************************************************
   // main sequence
   // *******************************************************************
   initial
   begin
      atappris_tck   = 1'b0;
      powergoodrst_b = 1'b0;
      atappris_tms   = 1'b1;
      atappris_tdi   = 1'b0;
      ip_status      = '0;
      seed           = 32'he963_988c;
      cycle_cnt      = 0;
      cycle_limit    = 0;
      total_cycles   = RESET_CYCLES;
      $readmemh("tap_rtdr_testdata.txt", test_mem);
      if (^test_mem[0] === 1'bx)
      begin
         $display("the test data file tap_rtdr_testdata.txt could not be read");
         $display("Test failed");
         $fatal(1, "no test data");
      end
      for (int r = 0; r < NUM_REC; r++)
      begin
         total_cycles = total_cycles
                        + record_cycles(test_mem[r*REC_WORDS], test_mem[r*REC_WORDS+1]);
      end
      cycle_limit = 2 * total_cycles;
      // reset spans four rising edges, released on a falling edge
      repeat (RESET_CYCLES) @(negedge atappris_tck);
      powergoodrst_b = 1'b1;
      for (int r = 0; r < NUM_REC; r++)
      begin
         run_record(r);
      end
      $display("Test completed successfully");
      $finish;
   end

endmodule
